// File: hdl/decode_pkg.sv
package decode_pkg;

// ####################
// widths
localparam int unsigned XLEN       = 32;
localparam int unsigned REG_ADDR_W = 5;
localparam int unsigned CSR_ADDR_W = 12;
localparam int unsigned TAG_W      = 4;

// ####################
// enumerations

// value n is bit n of the matcher hit vector
typedef enum logic [4:0] {
    KIND_NONE,
    KIND_LUI, KIND_AUIPC, KIND_JAL, KIND_JALR,
    KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE,
    KIND_LW, KIND_SW,
    KIND_ADDI, KIND_ORI, KIND_SLLI,
    KIND_ADD, KIND_SUB, KIND_OR, KIND_AND, KIND_XOR,
    KIND_FENCE, KIND_ECALL,
    KIND_CSRRW, KIND_CSRRS
} instr_kind_e;

typedef enum logic [1:0] {ALU_NOP, ALU_ADD, ALU_OR, ALU_SLL} alu_op_e;

typedef enum logic [2:0] {
    OPND_NONE, OPND_RS1, OPND_RS2, OPND_IMM, OPND_PC, OPND_CSR
} opnd_sel_e;

typedef enum logic [2:0] {WR_NONE, WR_ALU, WR_OP1, WR_BRANCH, WR_CSR} write_sel_e;

typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_BGE, BR_JAL, BR_JALR} branch_e;

typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS} csr_op_e;

// ####################
// micro-op
typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [TAG_W-1:0]      tag;
    logic                  valid;
    logic                  taken;
    logic [REG_ADDR_W-1:0] rs1;
    logic                  rs1_en;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  rs2_en;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_alloc;
    logic [XLEN-1:0]       imm;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic                  csr_en;
    csr_op_e               csr_op;
    alu_op_e               alu_op;
    opnd_sel_e             op1_sel;
    opnd_sel_e             op2_sel;
    write_sel_e            write_sel;
    branch_e               branch;
} uop_t;

// ####################
// opcode table, standard encodings
localparam logic [XLEN-1:0] MASK_LUI   = 32'h0000007f, MATCH_LUI   = 32'h00000037;
localparam logic [XLEN-1:0] MASK_AUIPC = 32'h0000007f, MATCH_AUIPC = 32'h00000017;
localparam logic [XLEN-1:0] MASK_JAL   = 32'h0000007f, MATCH_JAL   = 32'h0000006f;
localparam logic [XLEN-1:0] MASK_JALR  = 32'h0000707f, MATCH_JALR  = 32'h00000067;
localparam logic [XLEN-1:0] MASK_BEQ   = 32'h0000707f, MATCH_BEQ   = 32'h00000063;
localparam logic [XLEN-1:0] MASK_BNE   = 32'h0000707f, MATCH_BNE   = 32'h00001063;
localparam logic [XLEN-1:0] MASK_BLT   = 32'h0000707f, MATCH_BLT   = 32'h00004063;
localparam logic [XLEN-1:0] MASK_BGE   = 32'h0000707f, MATCH_BGE   = 32'h00005063;
localparam logic [XLEN-1:0] MASK_LW    = 32'h0000707f, MATCH_LW    = 32'h00002003;
localparam logic [XLEN-1:0] MASK_SW    = 32'h0000707f, MATCH_SW    = 32'h00002023;
localparam logic [XLEN-1:0] MASK_ADDI  = 32'h0000707f, MATCH_ADDI  = 32'h00000013;
localparam logic [XLEN-1:0] MASK_ORI   = 32'h0000707f, MATCH_ORI   = 32'h00006013;
localparam logic [XLEN-1:0] MASK_SLLI  = 32'hfe00707f, MATCH_SLLI  = 32'h00001013;
localparam logic [XLEN-1:0] MASK_ADD   = 32'hfe00707f, MATCH_ADD   = 32'h00000033;
localparam logic [XLEN-1:0] MASK_SUB   = 32'hfe00707f, MATCH_SUB   = 32'h40000033;
localparam logic [XLEN-1:0] MASK_OR    = 32'hfe00707f, MATCH_OR    = 32'h00006033;
localparam logic [XLEN-1:0] MASK_AND   = 32'hfe00707f, MATCH_AND   = 32'h00007033;
localparam logic [XLEN-1:0] MASK_XOR   = 32'hfe00707f, MATCH_XOR   = 32'h00004033;
localparam logic [XLEN-1:0] MASK_FENCE = 32'h0000707f, MATCH_FENCE = 32'h0000000f;
localparam logic [XLEN-1:0] MASK_ECALL = 32'hffffffff, MATCH_ECALL = 32'h00000073;
localparam logic [XLEN-1:0] MASK_CSRRW = 32'h0000707f, MATCH_CSRRW = 32'h00001073;
localparam logic [XLEN-1:0] MASK_CSRRS = 32'h0000707f, MATCH_CSRRS = 32'h00002073;

endpackage

// File: hdl/dec_fields_if.sv
`timescale 1ns/1ns

interface dec_fields_if;

decode_pkg::instr_kind_e               kind;
logic                                  active;
logic [decode_pkg::REG_ADDR_W-1:0]     rs1;
logic [decode_pkg::REG_ADDR_W-1:0]     rs2;
logic [decode_pkg::REG_ADDR_W-1:0]     rd;
logic [decode_pkg::CSR_ADDR_W-1:0]     csr_addr;
logic [decode_pkg::XLEN-1:0]           imm;

// classification side
modport match (output kind, output active);

// operand fields, immediate format picked by kind
modport extract (input kind, output rs1, output rs2, output rd, output csr_addr, output imm);

modport build (input kind, input active, input rs1, input rs2, input rd, input csr_addr,
               input imm);

endinterface

// File: hdl/instr_matcher.sv
`timescale 1ns/1ns

module instr_matcher
(
    input  logic [decode_pkg::XLEN-1:0] instr_i,
    input  logic                        fetch_valid_i,
    input  logic                        flush_i,
    output logic                        illegal_o,
    dec_fields_if.match                 fields
);

localparam int N_KINDS = 22;

logic               active;
logic [N_KINDS:1]   hit;

function automatic logic hit_of(
    input logic [decode_pkg::XLEN-1:0] instr,
    input logic [decode_pkg::XLEN-1:0] mask,
    input logic [decode_pkg::XLEN-1:0] pattern
);
    return (instr & mask) == pattern;
endfunction

assign active = fetch_valid_i && !flush_i;

// bit n follows kind value n
assign hit[1]  = hit_of(instr_i, decode_pkg::MASK_LUI, decode_pkg::MATCH_LUI);
assign hit[2]  = hit_of(instr_i, decode_pkg::MASK_AUIPC, decode_pkg::MATCH_AUIPC);
assign hit[3]  = hit_of(instr_i, decode_pkg::MASK_JAL, decode_pkg::MATCH_JAL);
assign hit[4]  = hit_of(instr_i, decode_pkg::MASK_JALR, decode_pkg::MATCH_JALR);
assign hit[5]  = hit_of(instr_i, decode_pkg::MASK_BEQ, decode_pkg::MATCH_BEQ);
assign hit[6]  = hit_of(instr_i, decode_pkg::MASK_BNE, decode_pkg::MATCH_BNE);
assign hit[7]  = hit_of(instr_i, decode_pkg::MASK_BLT, decode_pkg::MATCH_BLT);
assign hit[8]  = hit_of(instr_i, decode_pkg::MASK_BGE, decode_pkg::MATCH_BGE);
assign hit[9]  = hit_of(instr_i, decode_pkg::MASK_LW, decode_pkg::MATCH_LW);
assign hit[10] = hit_of(instr_i, decode_pkg::MASK_SW, decode_pkg::MATCH_SW);
assign hit[11] = hit_of(instr_i, decode_pkg::MASK_ADDI, decode_pkg::MATCH_ADDI);
assign hit[12] = hit_of(instr_i, decode_pkg::MASK_ORI, decode_pkg::MATCH_ORI);
assign hit[13] = hit_of(instr_i, decode_pkg::MASK_SLLI, decode_pkg::MATCH_SLLI);
assign hit[14] = hit_of(instr_i, decode_pkg::MASK_ADD, decode_pkg::MATCH_ADD);
assign hit[15] = hit_of(instr_i, decode_pkg::MASK_SUB, decode_pkg::MATCH_SUB);
assign hit[16] = hit_of(instr_i, decode_pkg::MASK_OR, decode_pkg::MATCH_OR);
assign hit[17] = hit_of(instr_i, decode_pkg::MASK_AND, decode_pkg::MATCH_AND);
assign hit[18] = hit_of(instr_i, decode_pkg::MASK_XOR, decode_pkg::MATCH_XOR);
assign hit[19] = hit_of(instr_i, decode_pkg::MASK_FENCE, decode_pkg::MATCH_FENCE);
assign hit[20] = hit_of(instr_i, decode_pkg::MASK_ECALL, decode_pkg::MATCH_ECALL);
assign hit[21] = hit_of(instr_i, decode_pkg::MASK_CSRRW, decode_pkg::MATCH_CSRRW);
assign hit[22] = hit_of(instr_i, decode_pkg::MASK_CSRRS, decode_pkg::MATCH_CSRRS);

always_comb
begin
    fields.kind = decode_pkg::KIND_NONE;
    for (int k = 1; k <= N_KINDS; k++)
    begin
        if (active && hit[k])
        begin
            fields.kind = decode_pkg::instr_kind_e'(5'(k));
        end
    end
end

assign fields.active = active;
assign illegal_o     = active && !(|hit);

// table entries must not overlap
table_onehot_chk: assert final ($onehot0(hit))
    else $error("instruction matched more than one table entry");

endmodule

// File: hdl/field_extract.sv
`timescale 1ns/1ns

module field_extract
(
    input  logic [decode_pkg::XLEN-1:0] instr_i,
    dec_fields_if.extract               fields
);

// fixed positions in every format
assign fields.rs1      = instr_i[19:15];
assign fields.rs2      = instr_i[24:20];
assign fields.rd       = instr_i[11:7];
assign fields.csr_addr = instr_i[31:20];

// ####################
// immediate per format
always_comb
begin
    case (fields.kind)
        decode_pkg::KIND_ADDI, decode_pkg::KIND_ORI, decode_pkg::KIND_JALR:
        begin
            fields.imm = {{20{instr_i[31]}}, instr_i[31:20]};
        end
        decode_pkg::KIND_SLLI:
        begin
            // shamt only
            fields.imm = {27'd0, instr_i[24:20]};
        end
        decode_pkg::KIND_LUI, decode_pkg::KIND_AUIPC:
        begin
            fields.imm = {instr_i[31:12], 12'd0};
        end
        decode_pkg::KIND_BEQ, decode_pkg::KIND_BNE, decode_pkg::KIND_BGE:
        begin
            fields.imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                          instr_i[11:8], 1'b0};
        end
        decode_pkg::KIND_JAL:
        begin
            fields.imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                          instr_i[30:21], 1'b0};
        end
        default:
        begin
            fields.imm = '0;
        end
    endcase
end

endmodule

// File: hdl/uop_builder.sv
`timescale 1ns/1ns

module uop_builder
(
    input  logic [decode_pkg::XLEN-1:0] pc_i,
    input  logic                        taken_i,
    dec_fields_if.build                 fields,
    output decode_pkg::uop_t            uop_next_o,
    output logic                        advance_tag_o
);

always_comb
begin
    uop_next_o       = '0;
    advance_tag_o    = 1'b1;
    uop_next_o.pc    = pc_i;
    // tag mask, the stage register ands in its counter
    uop_next_o.tag   = '1;
    uop_next_o.valid = fields.active;
    uop_next_o.taken = taken_i;

    case (fields.kind)
        decode_pkg::KIND_LUI:
        begin
            uop_next_o.imm       = fields.imm;
            uop_next_o.op1_sel   = decode_pkg::OPND_IMM;
            uop_next_o.rd        = fields.rd;
            uop_next_o.rd_alloc  = 1'b1;
            uop_next_o.write_sel = decode_pkg::WR_OP1;
        end
        decode_pkg::KIND_AUIPC:
        begin
            // rd left unallocated
            uop_next_o.imm       = fields.imm;
            uop_next_o.op1_sel   = decode_pkg::OPND_PC;
            uop_next_o.op2_sel   = decode_pkg::OPND_IMM;
            uop_next_o.alu_op    = decode_pkg::ALU_ADD;
            uop_next_o.write_sel = decode_pkg::WR_ALU;
        end
        decode_pkg::KIND_JAL, decode_pkg::KIND_JALR:
        begin
            uop_next_o.rd        = fields.rd;
            uop_next_o.rd_alloc  = 1'b1;
            uop_next_o.imm       = fields.imm;
            uop_next_o.branch    = (fields.kind == decode_pkg::KIND_JAL) ?
                                   decode_pkg::BR_JAL : decode_pkg::BR_JALR;
            uop_next_o.write_sel = decode_pkg::WR_BRANCH;
        end
        decode_pkg::KIND_BEQ, decode_pkg::KIND_BNE, decode_pkg::KIND_BGE:
        begin
            uop_next_o.rs1     = fields.rs1;
            uop_next_o.rs1_en  = 1'b1;
            uop_next_o.rs2     = fields.rs2;
            uop_next_o.rs2_en  = 1'b1;
            uop_next_o.imm     = fields.imm;
            uop_next_o.op1_sel = decode_pkg::OPND_RS1;
            uop_next_o.op2_sel = decode_pkg::OPND_RS2;
            uop_next_o.branch  = (fields.kind == decode_pkg::KIND_BEQ) ? decode_pkg::BR_BEQ :
                                 (fields.kind == decode_pkg::KIND_BNE) ? decode_pkg::BR_BNE :
                                 decode_pkg::BR_BGE;
        end
        decode_pkg::KIND_ADDI, decode_pkg::KIND_ORI, decode_pkg::KIND_SLLI:
        begin
            uop_next_o.rs1       = fields.rs1;
            uop_next_o.rs1_en    = 1'b1;
            uop_next_o.imm       = fields.imm;
            uop_next_o.rd        = fields.rd;
            uop_next_o.rd_alloc  = 1'b1;
            uop_next_o.op1_sel   = decode_pkg::OPND_RS1;
            uop_next_o.op2_sel   = decode_pkg::OPND_IMM;
            uop_next_o.alu_op    = (fields.kind == decode_pkg::KIND_ADDI) ? decode_pkg::ALU_ADD :
                                   (fields.kind == decode_pkg::KIND_ORI)  ? decode_pkg::ALU_OR :
                                   decode_pkg::ALU_SLL;
            uop_next_o.write_sel = decode_pkg::WR_ALU;
        end
        decode_pkg::KIND_ADD, decode_pkg::KIND_OR:
        begin
            uop_next_o.rs1       = fields.rs1;
            uop_next_o.rs1_en    = 1'b1;
            uop_next_o.rs2       = fields.rs2;
            uop_next_o.rs2_en    = 1'b1;
            uop_next_o.rd        = fields.rd;
            uop_next_o.rd_alloc  = 1'b1;
            uop_next_o.op1_sel   = decode_pkg::OPND_RS1;
            uop_next_o.op2_sel   = decode_pkg::OPND_RS2;
            uop_next_o.alu_op    = (fields.kind == decode_pkg::KIND_ADD) ?
                                   decode_pkg::ALU_ADD : decode_pkg::ALU_OR;
            uop_next_o.write_sel = decode_pkg::WR_ALU;
        end
        decode_pkg::KIND_CSRRW, decode_pkg::KIND_CSRRS:
        begin
            uop_next_o.rs1       = fields.rs1;
            uop_next_o.rs1_en    = 1'b1;
            uop_next_o.rd        = fields.rd;
            uop_next_o.rd_alloc  = 1'b1;
            uop_next_o.csr_addr  = fields.csr_addr;
            uop_next_o.csr_en    = 1'b1;
            uop_next_o.csr_op    = decode_pkg::CSR_RW;
            uop_next_o.write_sel = decode_pkg::WR_CSR;
            if (fields.kind == decode_pkg::KIND_CSRRS)
            begin
                // read-set goes through the ALU as csr | rs1
                uop_next_o.csr_op  = decode_pkg::CSR_RS;
                uop_next_o.alu_op  = decode_pkg::ALU_OR;
                uop_next_o.op1_sel = decode_pkg::OPND_RS1;
                uop_next_o.op2_sel = decode_pkg::OPND_CSR;
            end
        end
        decode_pkg::KIND_NONE:
        begin
            // illegal or inactive, base fields only
            advance_tag_o = 1'b0;
        end
        default:
        begin
            // recognised, issued as a bare no-op
            uop_next_o       = '0;
            uop_next_o.valid = 1'b1;
            advance_tag_o    = 1'b0;
        end
    endcase
end

endmodule

// File: hdl/uop_stage_reg.sv
`timescale 1ns/1ns

module uop_stage_reg
(
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             stall_i,
    input  decode_pkg::uop_t uop_next_i,
    input  logic             advance_tag_i,
    output decode_pkg::uop_t uop_o
);

logic [decode_pkg::TAG_W-1:0]   tag_q;
decode_pkg::uop_t               uop_q;
decode_pkg::uop_t               uop_tagged;

// mask from the builder is zero for no-op kinds
always_comb
begin
    uop_tagged     = uop_next_i;
    uop_tagged.tag = uop_next_i.tag & tag_q;
end

// ####################
// register and tag counter
always_ff @(posedge clk_i)
begin
    if (!rstn_i)
    begin
        uop_q <= '0;
        tag_q <= '0;
    end
    else if (!stall_i)
    begin
        uop_q <= uop_tagged;
        if (advance_tag_i)
        begin
            // wraps at 2**TAG_W
            tag_q <= tag_q + 1'b1;
        end
    end
end

assign uop_o = uop_q;

stall_hold_chk: assert property (@(posedge clk_i) disable iff (!rstn_i)
    stall_i |=> $stable(uop_o))
    else $error("uop changed in the cycle after a stall");

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
(
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic [decode_pkg::XLEN-1:0] instr_i,
    input  logic [decode_pkg::XLEN-1:0] pc_i,
    input  logic                        fetch_valid_i,
    input  logic                        taken_i,
    input  logic                        flush_i,
    input  logic                        stall_i,
    output logic                        illegal_o,
    output decode_pkg::uop_t            uop_o
);

decode_pkg::uop_t   uop_next;
logic               advance_tag;

dec_fields_if fields ();

// ####################
// combinational decode
instr_matcher u_matcher
(
    .instr_i       (instr_i),
    .fetch_valid_i (fetch_valid_i),
    .flush_i       (flush_i),
    .illegal_o     (illegal_o),
    .fields        (fields.match)
);

field_extract u_extract
(
    .instr_i (instr_i),
    .fields  (fields.extract)
);

uop_builder u_builder
(
    .pc_i          (pc_i),
    .taken_i       (taken_i),
    .fields        (fields.build),
    .uop_next_o    (uop_next),
    .advance_tag_o (advance_tag)
);

// one cycle to the output
uop_stage_reg u_stage_reg
(
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .stall_i       (stall_i),
    .uop_next_i    (uop_next),
    .advance_tag_i (advance_tag),
    .uop_o         (uop_o)
);

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
)
(
    output logic clk_o,
    output logic rstn_o
);

initial
begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
end

// release on a rising edge so the DUT sees a full reset cycle count
initial
begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rstn_o <= 1'b1;
end

endmodule

// File: tb/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage;

localparam int N_TESTS     = 6;
localparam int WATCHDOG_NS = N_TESTS * 2000 + 500;

// one instruction as the testbench sees it, before encoding
typedef struct packed {
    decode_pkg::instr_kind_e kind;
    logic [4:0]              rd;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [31:0]             imm;
} op_t;

logic                         clk;
logic                         rstn;
logic [decode_pkg::XLEN-1:0]  instr;
logic [decode_pkg::XLEN-1:0]  pc;
logic                         fetch_valid;
logic                         taken;
logic                         flush;
logic                         stall;
logic                         illegal;
decode_pkg::uop_t             uop;

integer                       seed = 32'h21295fec;
int                           error_count = 0;
logic [decode_pkg::TAG_W-1:0] model_tag = '0;
decode_pkg::uop_t             exp_out = '0;

tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(10)) u_clk_gen
(
    .clk_o  (clk),
    .rstn_o (rstn)
);

decode_stage UUT
(
    .clk_i         (clk),
    .rstn_i        (rstn),
    .instr_i       (instr),
    .pc_i          (pc),
    .fetch_valid_i (fetch_valid),
    .taken_i       (taken),
    .flush_i       (flush),
    .stall_i       (stall),
    .illegal_o     (illegal),
    .uop_o         (uop)
);

// ####################
// encoder
function automatic logic [31:0] i_type(input op_t op, input logic [2:0] f3,
                                       input logic [6:0] opc);
    return {op.imm[11:0], op.rs1, f3, op.rd, opc};
endfunction

function automatic logic [31:0] b_type(input op_t op, input logic [2:0] f3);
    return {op.imm[12], op.imm[10:5], op.rs2, op.rs1, f3, op.imm[4:1], op.imm[11], 7'h63};
endfunction

function automatic logic [31:0] r_type(input op_t op, input logic [6:0] f7,
                                       input logic [2:0] f3);
    return {f7, op.rs2, op.rs1, f3, op.rd, 7'h33};
endfunction

function automatic logic [31:0] encode(input op_t op);
    logic [31:0] i;
    i = op.imm;
    case (op.kind)
        decode_pkg::KIND_LUI:   return {i[31:12], op.rd, 7'h37};
        decode_pkg::KIND_AUIPC: return {i[31:12], op.rd, 7'h17};
        decode_pkg::KIND_JAL:   return {i[20], i[10:1], i[11], i[19:12], op.rd, 7'h6f};
        decode_pkg::KIND_JALR:  return i_type(op, 3'd0, 7'h67);
        decode_pkg::KIND_BEQ:   return b_type(op, 3'd0);
        decode_pkg::KIND_BNE:   return b_type(op, 3'd1);
        decode_pkg::KIND_BLT:   return b_type(op, 3'd4);
        decode_pkg::KIND_BGE:   return b_type(op, 3'd5);
        decode_pkg::KIND_LW:    return i_type(op, 3'd2, 7'h03);
        decode_pkg::KIND_SW:    return {i[11:5], op.rs2, op.rs1, 3'd2, i[4:0], 7'h23};
        decode_pkg::KIND_ADDI:  return i_type(op, 3'd0, 7'h13);
        decode_pkg::KIND_ORI:   return i_type(op, 3'd6, 7'h13);
        decode_pkg::KIND_SLLI:  return {7'd0, i[4:0], op.rs1, 3'd1, op.rd, 7'h13};
        decode_pkg::KIND_ADD:   return r_type(op, 7'h00, 3'd0);
        decode_pkg::KIND_SUB:   return r_type(op, 7'h20, 3'd0);
        decode_pkg::KIND_OR:    return r_type(op, 7'h00, 3'd6);
        decode_pkg::KIND_AND:   return r_type(op, 7'h00, 3'd7);
        decode_pkg::KIND_XOR:   return r_type(op, 7'h00, 3'd4);
        decode_pkg::KIND_FENCE: return i_type(op, 3'd0, 7'h0f);
        decode_pkg::KIND_ECALL: return 32'h00000073;
        // csr address rides in imm[11:0]
        decode_pkg::KIND_CSRRW: return i_type(op, 3'd1, 7'h73);
        decode_pkg::KIND_CSRRS: return i_type(op, 3'd2, 7'h73);
        default:                return 32'd0;
    endcase
endfunction

// ####################
// reference model
function automatic logic fully_decoded(input decode_pkg::instr_kind_e kind);
    case (kind)
        decode_pkg::KIND_LUI, decode_pkg::KIND_AUIPC, decode_pkg::KIND_JAL,
        decode_pkg::KIND_JALR, decode_pkg::KIND_BEQ, decode_pkg::KIND_BNE,
        decode_pkg::KIND_BGE, decode_pkg::KIND_ADDI, decode_pkg::KIND_ORI,
        decode_pkg::KIND_SLLI, decode_pkg::KIND_ADD, decode_pkg::KIND_OR,
        decode_pkg::KIND_CSRRW, decode_pkg::KIND_CSRRS: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic decode_pkg::uop_t model_uop(input op_t op, input logic [31:0] pc_v,
        input logic taken_v, input logic act, input logic [decode_pkg::TAG_W-1:0] tag);
    decode_pkg::uop_t u;
    u = '0;
    // recognised no-op kinds carry nothing but valid
    if (act && op.kind != decode_pkg::KIND_NONE && !fully_decoded(op.kind))
    begin
        u.valid = 1'b1;
        return u;
    end
    u.pc    = pc_v;
    u.tag   = tag;
    u.valid = act;
    u.taken = taken_v;
    if (!act)
    begin
        return u;
    end
    case (op.kind)
        decode_pkg::KIND_LUI:
        begin
            u.imm       = op.imm;
            u.op1_sel   = decode_pkg::OPND_IMM;
            u.rd        = op.rd;
            u.rd_alloc  = 1'b1;
            u.write_sel = decode_pkg::WR_OP1;
        end
        decode_pkg::KIND_AUIPC:
        begin
            u.imm       = op.imm;
            u.op1_sel   = decode_pkg::OPND_PC;
            u.op2_sel   = decode_pkg::OPND_IMM;
            u.alu_op    = decode_pkg::ALU_ADD;
            u.write_sel = decode_pkg::WR_ALU;
        end
        decode_pkg::KIND_JAL, decode_pkg::KIND_JALR:
        begin
            u.rd        = op.rd;
            u.rd_alloc  = 1'b1;
            u.imm       = op.imm;
            u.branch    = (op.kind == decode_pkg::KIND_JAL) ? decode_pkg::BR_JAL
                                                            : decode_pkg::BR_JALR;
            u.write_sel = decode_pkg::WR_BRANCH;
        end
        decode_pkg::KIND_BEQ, decode_pkg::KIND_BNE, decode_pkg::KIND_BGE:
        begin
            {u.rs1, u.rs1_en, u.rs2, u.rs2_en} = {op.rs1, 1'b1, op.rs2, 1'b1};
            u.imm     = op.imm;
            u.op1_sel = decode_pkg::OPND_RS1;
            u.op2_sel = decode_pkg::OPND_RS2;
            u.branch  = (op.kind == decode_pkg::KIND_BEQ) ? decode_pkg::BR_BEQ :
                        (op.kind == decode_pkg::KIND_BNE) ? decode_pkg::BR_BNE :
                        decode_pkg::BR_BGE;
        end
        decode_pkg::KIND_ADDI, decode_pkg::KIND_ORI, decode_pkg::KIND_SLLI:
        begin
            {u.rs1, u.rs1_en, u.rd, u.rd_alloc} = {op.rs1, 1'b1, op.rd, 1'b1};
            u.imm       = op.imm;
            u.op1_sel   = decode_pkg::OPND_RS1;
            u.op2_sel   = decode_pkg::OPND_IMM;
            u.alu_op    = (op.kind == decode_pkg::KIND_ADDI) ? decode_pkg::ALU_ADD :
                          (op.kind == decode_pkg::KIND_ORI)  ? decode_pkg::ALU_OR :
                          decode_pkg::ALU_SLL;
            u.write_sel = decode_pkg::WR_ALU;
        end
        decode_pkg::KIND_ADD, decode_pkg::KIND_OR:
        begin
            {u.rs1, u.rs1_en, u.rs2, u.rs2_en} = {op.rs1, 1'b1, op.rs2, 1'b1};
            {u.rd, u.rd_alloc} = {op.rd, 1'b1};
            u.op1_sel   = decode_pkg::OPND_RS1;
            u.op2_sel   = decode_pkg::OPND_RS2;
            u.alu_op    = (op.kind == decode_pkg::KIND_ADD) ? decode_pkg::ALU_ADD
                                                            : decode_pkg::ALU_OR;
            u.write_sel = decode_pkg::WR_ALU;
        end
        decode_pkg::KIND_CSRRW, decode_pkg::KIND_CSRRS:
        begin
            {u.rs1, u.rs1_en, u.rd, u.rd_alloc} = {op.rs1, 1'b1, op.rd, 1'b1};
            u.csr_addr  = op.imm[11:0];
            u.csr_en    = 1'b1;
            u.csr_op    = decode_pkg::CSR_RW;
            u.write_sel = decode_pkg::WR_CSR;
            if (op.kind == decode_pkg::KIND_CSRRS)
            begin
                u.csr_op  = decode_pkg::CSR_RS;
                u.alu_op  = decode_pkg::ALU_OR;
                u.op1_sel = decode_pkg::OPND_RS1;
                u.op2_sel = decode_pkg::OPND_CSR;
            end
        end
        default:
        begin
            // illegal word, base fields only
        end
    endcase
    return u;
endfunction

// ####################
// checks
task automatic abort_run(input string msg);
    error_count++;
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopping at first error");
endtask

task automatic compare_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (act_v !== exp_v)
    begin
        abort_run($sformatf("[FAIL] t=%0t %s expected %h actual %h",
                            $time, name, exp_v, act_v));
    end
endtask

task automatic check_flag(input logic exp_v);
    compare_field("illegal_o", {31'd0, exp_v}, {31'd0, illegal});
endtask

task automatic check_uop(input decode_pkg::uop_t exp_v);
    compare_field("uop_o.pc", exp_v.pc, uop.pc);
    compare_field("uop_o.tag", exp_v.tag, uop.tag);
    compare_field("uop_o.valid", exp_v.valid, uop.valid);
    compare_field("uop_o.taken", exp_v.taken, uop.taken);
    compare_field("uop_o.rs1", exp_v.rs1, uop.rs1);
    compare_field("uop_o.rs1_en", exp_v.rs1_en, uop.rs1_en);
    compare_field("uop_o.rs2", exp_v.rs2, uop.rs2);
    compare_field("uop_o.rs2_en", exp_v.rs2_en, uop.rs2_en);
    compare_field("uop_o.rd", exp_v.rd, uop.rd);
    compare_field("uop_o.rd_alloc", exp_v.rd_alloc, uop.rd_alloc);
    compare_field("uop_o.imm", exp_v.imm, uop.imm);
    compare_field("uop_o.csr_addr", exp_v.csr_addr, uop.csr_addr);
    compare_field("uop_o.csr_en", exp_v.csr_en, uop.csr_en);
    compare_field("uop_o.csr_op", exp_v.csr_op, uop.csr_op);
    compare_field("uop_o.alu_op", exp_v.alu_op, uop.alu_op);
    compare_field("uop_o.op1_sel", exp_v.op1_sel, uop.op1_sel);
    compare_field("uop_o.op2_sel", exp_v.op2_sel, uop.op2_sel);
    compare_field("uop_o.write_sel", exp_v.write_sel, uop.write_sel);
    compare_field("uop_o.branch", exp_v.branch, uop.branch);
endtask

// ####################
// stimulus
task automatic make_op(input decode_pkg::instr_kind_e kind, input logic neg, output op_t op);
    logic [31:0] r;
    logic [31:0] regs;
    r    = $random(seed);
    regs = $random(seed);
    if (neg)
    begin
        r[31] = 1'b1;
    end
    op.kind = kind;
    op.rd   = regs[4:0];
    op.rs1  = regs[9:5];
    op.rs2  = regs[14:10];
    case (kind)
        decode_pkg::KIND_LUI, decode_pkg::KIND_AUIPC: op.imm = {r[31:12], 12'd0};
        decode_pkg::KIND_JAL:                         op.imm = {{11{r[31]}}, r[31:12], 1'b0};
        decode_pkg::KIND_BEQ, decode_pkg::KIND_BNE, decode_pkg::KIND_BLT,
        decode_pkg::KIND_BGE:                         op.imm = {{19{r[31]}}, r[31:20], 1'b0};
        decode_pkg::KIND_SLLI:                        op.imm = {27'd0, r[4:0]};
        decode_pkg::KIND_CSRRW, decode_pkg::KIND_CSRRS: op.imm = {20'd0, r[31:20]};
        decode_pkg::KIND_JALR, decode_pkg::KIND_ADDI, decode_pkg::KIND_ORI,
        decode_pkg::KIND_LW, decode_pkg::KIND_SW,
        decode_pkg::KIND_FENCE:                       op.imm = {{20{r[31]}}, r[31:20]};
        default:                                      op.imm = 32'd0;
    endcase
endtask

// drives one word; flag checked for it, uop checked for the word before
task automatic step(input op_t op, input logic [31:0] pc_v, input logic taken_v,
                    input logic fv_v, input logic flush_v, input logic stall_v);
    logic act;
    act = fv_v && !flush_v;
    @(posedge clk);
    instr       <= encode(op);
    pc          <= pc_v;
    taken       <= taken_v;
    fetch_valid <= fv_v;
    flush       <= flush_v;
    stall       <= stall_v;
    @(negedge clk);
    check_flag(act && op.kind == decode_pkg::KIND_NONE);
    check_uop(exp_out);
    if (!stall_v)
    begin
        exp_out = model_uop(op, pc_v, taken_v, act, model_tag);
        if (act && fully_decoded(op.kind))
        begin
            model_tag = model_tag + 1'b1;
        end
    end
endtask

task automatic issue(input decode_pkg::instr_kind_e kind, input logic neg,
                     input logic stall_v);
    op_t         op;
    logic [31:0] r;
    make_op(kind, neg, op);
    r = $random(seed);
    step(op, {r[31:2], 2'b00}, r[1], 1'b1, 1'b0, stall_v);
endtask

// ####################
// directed tests
task automatic reset_values();
    wait (rstn === 1'b1);
    @(negedge clk);
    check_flag(1'b0);
    check_uop(exp_out);
    issue(decode_pkg::KIND_ADDI, 1'b0, 1'b0);
endtask

task automatic alu_upper_decode();
    repeat (4)
    begin
        issue(decode_pkg::KIND_LUI, 1'b0, 1'b0);
        issue(decode_pkg::KIND_AUIPC, 1'b0, 1'b0);
        issue(decode_pkg::KIND_ADDI, 1'b0, 1'b0);
        issue(decode_pkg::KIND_ORI, 1'b0, 1'b0);
        issue(decode_pkg::KIND_SLLI, 1'b0, 1'b0);
        issue(decode_pkg::KIND_ADD, 1'b0, 1'b0);
        issue(decode_pkg::KIND_OR, 1'b0, 1'b0);
    end
endtask

task automatic branch_decode();
    for (int i = 0; i < 4; i++)
    begin
        // odd passes force a negative offset
        issue(decode_pkg::KIND_BEQ, i[0], 1'b0);
        issue(decode_pkg::KIND_BNE, i[0], 1'b0);
        issue(decode_pkg::KIND_BGE, i[0], 1'b0);
        issue(decode_pkg::KIND_JAL, i[0], 1'b0);
        issue(decode_pkg::KIND_JALR, i[0], 1'b0);
    end
endtask

task automatic csr_decode();
    repeat (4)
    begin
        issue(decode_pkg::KIND_CSRRW, 1'b0, 1'b0);
        issue(decode_pkg::KIND_CSRRS, 1'b0, 1'b0);
    end
endtask

task automatic noop_and_illegal();
    issue(decode_pkg::KIND_BLT, 1'b0, 1'b0);
    issue(decode_pkg::KIND_LW, 1'b0, 1'b0);
    issue(decode_pkg::KIND_SW, 1'b0, 1'b0);
    issue(decode_pkg::KIND_SUB, 1'b0, 1'b0);
    issue(decode_pkg::KIND_AND, 1'b0, 1'b0);
    issue(decode_pkg::KIND_XOR, 1'b0, 1'b0);
    issue(decode_pkg::KIND_FENCE, 1'b0, 1'b0);
    issue(decode_pkg::KIND_ECALL, 1'b0, 1'b0);
    // all-zero word
    issue(decode_pkg::KIND_NONE, 1'b0, 1'b0);
    issue(decode_pkg::KIND_ADDI, 1'b0, 1'b0);
endtask

task automatic stall_and_flush();
    op_t op;
    issue(decode_pkg::KIND_ADDI, 1'b0, 1'b0);
    repeat (4)
    begin
        issue(decode_pkg::KIND_ORI, 1'b0, 1'b1);
    end
    issue(decode_pkg::KIND_ADD, 1'b0, 1'b0);
    make_op(decode_pkg::KIND_ADDI, 1'b0, op);
    step(op, 32'h0000_0100, 1'b1, 1'b1, 1'b1, 1'b0);
    step(op, 32'h0000_0104, 1'b1, 1'b0, 1'b0, 1'b0);
    // flushed illegal word must not flag
    make_op(decode_pkg::KIND_NONE, 1'b0, op);
    step(op, 32'h0000_0108, 1'b0, 1'b1, 1'b1, 1'b0);
    issue(decode_pkg::KIND_OR, 1'b0, 1'b0);
endtask

initial
begin
    #(WATCHDOG_NS);
    abort_run($sformatf("timeout: tests did not finish within %0d ns", WATCHDOG_NS));
end

initial
begin
    op_t idle_op;
    instr       = '0;
    pc          = '0;
    fetch_valid = 1'b0;
    taken       = 1'b0;
    flush       = 1'b0;
    stall       = 1'b0;
    idle_op     = '0;
    reset_values();
    alu_upper_decode();
    branch_decode();
    csr_decode();
    noop_and_illegal();
    stall_and_flush();
    // drain the last uop
    step(idle_op, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);
    if (error_count == 0)
    begin
        $display("STATUS: PASS");
    end
    else
    begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

// File: filelist.f
hdl/decode_pkg.sv
hdl/dec_fields_if.sv
hdl/instr_matcher.sv
hdl/field_extract.sv
hdl/uop_builder.sv
hdl/uop_stage_reg.sv
hdl/decode_stage.sv
tb/tb_clock_gen.sv
tb/tb_decode_stage.sv
